// File: hdl/attn_pkg.sv
// ########################################
// Attention score package
// Fixed-point formats, vector types and dimensions
// ########################################
`default_nettype none

package attn_pkg;

    // Vector length, must be a power of four
    localparam int EMBED_DIM = 16;
    // One adder level per halving of the operand count
    localparam int REDUCE_STAGES = $clog2(EMBED_DIM);
    // Divide by sqrt(EMBED_DIM) as a shift
    localparam int SCALE_SHIFT = REDUCE_STAGES / 2;

    // Q1.7 vector element
    localparam int ELEM_I = 1;
    localparam int ELEM_F = 7;
    // Q2.14 full multiplier result
    localparam int PRODUCT_RAW_I = 2;
    localparam int PRODUCT_RAW_F = 14;
    // Q2.10 requantized product
    localparam int PRODUCT_I = 2;
    localparam int PRODUCT_F = 10;
    // Q6.10 tree sum, 16 products cannot overflow it
    localparam int DOT_I = 6;
    localparam int DOT_F = 10;
    // Q4.4 saturated score
    localparam int SCORE_I = 4;
    localparam int SCORE_F = 4;

    typedef logic signed [ELEM_I+ELEM_F-1:0] elem_t;
    typedef logic signed [PRODUCT_RAW_I+PRODUCT_RAW_F-1:0] raw_product_t;
    typedef logic signed [PRODUCT_I+PRODUCT_F-1:0] product_t;
    typedef logic signed [DOT_I+DOT_F-1:0] dot_t;
    typedef logic signed [SCORE_I+SCORE_F-1:0] score_t;

    // Q, K and V rows
    typedef elem_t [EMBED_DIM-1:0] vec_t;

    // One output row, score with its V
    typedef struct packed {
        score_t score;
        vec_t   v;
    } score_beat_t;

endpackage

`default_nettype wire

// File: hdl/q_convert.sv
// ########################################
// Fixed-point format converter
// Truncates fraction, saturates integer part
// ########################################
`timescale 1ns/1ns
`default_nettype none

module q_convert #(
    parameter int IN_I  = 2,
    parameter int IN_F  = 14,
    parameter int OUT_I = 2,
    parameter int OUT_F = 10
) (
    input  logic signed [IN_I+IN_F-1:0]   in,
    output logic signed [OUT_I+OUT_F-1:0] out
);

    localparam int IN_W  = IN_I + IN_F;
    localparam int OUT_W = OUT_I + OUT_F;
    // Only one of the two shifts is nonzero
    localparam int SHL = (OUT_F > IN_F) ? OUT_F - IN_F : 0;
    localparam int SHR = (IN_F > OUT_F) ? IN_F - OUT_F : 0;
    // One guard bit above the wider of aligned input and output
    localparam int WIDE_W = (((IN_W + SHL) > OUT_W) ? (IN_W + SHL) : OUT_W) + 1;

    logic signed [WIDE_W-1:0] wide;
    logic signed [WIDE_W-1:0] max_v;
    logic signed [WIDE_W-1:0] min_v;

    // Output range limits in the wide format
    assign max_v = {{(WIDE_W-OUT_W+1){1'b0}}, {(OUT_W-1){1'b1}}};
    assign min_v = ~max_v;

    always_comb begin
        wide = in;
        // Arithmetic right shift floors toward minus infinity
        wide = (wide <<< SHL) >>> SHR;
        if (wide > max_v) begin
            out = max_v[OUT_W-1:0];
        end else if (wide < min_v) begin
            out = min_v[OUT_W-1:0];
        end else begin
            out = wide[OUT_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/tree_reduce.sv
// ########################################
// Pipelined adder tree with flow control
// Carries a side payload next to the sum
// ########################################
`timescale 1ns/1ns
`default_nettype none

module tree_reduce #(
    parameter int  N_IN   = 16,
    parameter type side_t = logic
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  attn_pkg::product_t leaves [N_IN],
    input  side_t              side_in,
    output logic               out_valid,
    input  logic               out_ready,
    output attn_pkg::dot_t     sum,
    output side_t              side_out
);

    localparam int LEVELS = $clog2(N_IN);

    // Level l holds N_IN >> l partial sums, packed level after level
    attn_pkg::dot_t node [N_IN-1];
    side_t side_r [1:LEVELS];
    side_t src_side [1:LEVELS];
    logic [LEVELS:1] lvl_valid;
    logic [LEVELS:1] src_valid;
    // Level can take new contents
    logic [LEVELS:1] lvl_acc;
    // Level contents move on
    logic [LEVELS:1] lvl_adv;
    logic [LEVELS:1] lvl_load;

    for (genvar l = 1; l <= LEVELS; l++) begin : g_level
        localparam int CNT = N_IN >> l;
        localparam int DST = N_IN - (N_IN >> (l - 1));
        // Previous level starts two level widths below
        localparam int SRC = DST - 2 * CNT;

        // First level sums the leaves, later ones the level before
        if (l == 1) begin : g_src
            assign src_valid[l] = in_valid;
            assign src_side[l]  = side_in;
            for (genvar j = 0; j < CNT; j++) begin : g_add
                always_ff @(posedge clk) begin
                    if (lvl_load[l]) begin
                        node[DST+j] <= attn_pkg::dot_t'(leaves[2*j])
                                     + attn_pkg::dot_t'(leaves[2*j+1]);
                    end
                end
            end
        end else begin : g_src
            assign src_valid[l] = lvl_valid[l-1];
            assign src_side[l]  = side_r[l-1];
            for (genvar j = 0; j < CNT; j++) begin : g_add
                always_ff @(posedge clk) begin
                    if (lvl_load[l]) begin
                        node[DST+j] <= node[SRC+2*j] + node[SRC+2*j+1];
                    end
                end
            end
        end

        // Last level drains to the output, others into the next level
        if (l == LEVELS) begin : g_adv
            assign lvl_adv[l] = out_ready;
        end else begin : g_adv
            assign lvl_adv[l] = lvl_acc[l+1];
        end

        // Empty or draining levels accept, so bubbles collapse
        assign lvl_acc[l]  = !lvl_valid[l] || lvl_adv[l];
        assign lvl_load[l] = lvl_acc[l] && src_valid[l];

        always_ff @(posedge clk) begin
            if (rst) begin
                lvl_valid[l] <= 1'b0;
            end else if (lvl_acc[l]) begin
                lvl_valid[l] <= src_valid[l];
            end
        end

        always_ff @(posedge clk) begin
            if (lvl_load[l]) begin
                side_r[l] <= src_side[l];
            end
        end
    end

    assign in_ready  = lvl_acc[1];
    assign out_valid = lvl_valid[LEVELS];
    // Final level is the single root node
    assign sum       = node[N_IN-2];
    assign side_out  = side_r[LEVELS];

endmodule

`default_nettype wire

// File: hdl/dot_product.sv
// ########################################
// Scaled Q.K dot product with V passthrough
// ########################################
`timescale 1ns/1ns
`default_nettype none

module dot_product #(
    parameter int SEQ_LEN = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  attn_pkg::vec_t        q_in,
    input  attn_pkg::vec_t        k_in,
    input  attn_pkg::vec_t        v_in,
    input  logic                  q_valid,
    input  logic                  k_valid,
    input  logic                  v_valid,
    output logic                  q_ready,
    output logic                  k_ready,
    output logic                  v_ready,
    output attn_pkg::score_beat_t beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    localparam int CNT_W = (SEQ_LEN > 1) ? $clog2(SEQ_LEN) : 1;

    // Input registers
    attn_pkg::vec_t q_r;
    attn_pkg::vec_t k_r;
    attn_pkg::vec_t v_r;
    logic q_held;
    logic k_held;
    logic v_held;
    // Rows left for the held Q after the current one
    logic [CNT_W-1:0] row_cnt;

    logic all_valid;
    logic tree_ready;
    logic row_fire;
    logic last_row;

    attn_pkg::raw_product_t raw [attn_pkg::EMBED_DIM];
    attn_pkg::product_t prod [attn_pkg::EMBED_DIM];
    attn_pkg::dot_t sum;
    attn_pkg::dot_t scaled;
    attn_pkg::score_t score;
    attn_pkg::vec_t v_out;

    assign all_valid = q_held && k_held && v_held;
    // Row enters the tree
    assign row_fire  = all_valid && tree_ready;
    assign last_row  = (row_cnt == '0);

    // Q is replaced only once its last row enters the tree
    assign q_ready = !q_held || (row_fire && last_row);
    assign k_ready = !k_held || row_fire;
    assign v_ready = !v_held || row_fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            q_held  <= 1'b0;
            row_cnt <= '0;
        end else if (q_valid && q_ready) begin
            q_held  <= 1'b1;
            row_cnt <= CNT_W'(SEQ_LEN - 1);
        end else if (row_fire) begin
            if (last_row) begin
                q_held <= 1'b0;
            end else begin
                row_cnt <= row_cnt - 1'b1;
            end
        end
    end

    // K and V valid bits follow the same rule
    always_ff @(posedge clk) begin
        if (rst) begin
            k_held <= 1'b0;
            v_held <= 1'b0;
        end else begin
            if (k_valid && k_ready) begin
                k_held <= 1'b1;
            end else if (row_fire) begin
                k_held <= 1'b0;
            end
            if (v_valid && v_ready) begin
                v_held <= 1'b1;
            end else if (row_fire) begin
                v_held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (q_valid && q_ready) begin
            q_r <= q_in;
        end
        if (k_valid && k_ready) begin
            k_r <= k_in;
        end
        if (v_valid && v_ready) begin
            v_r <= v_in;
        end
    end

    // Full Q2.14 products, signed 8x8 in a 16 bit context
    always_comb begin
        for (int i = 0; i < attn_pkg::EMBED_DIM; i++) begin
            raw[i] = q_r[i] * k_r[i];
        end
    end

    for (genvar p = 0; p < attn_pkg::EMBED_DIM; p++) begin : g_prod
        q_convert #(
            .IN_I  (attn_pkg::PRODUCT_RAW_I),
            .IN_F  (attn_pkg::PRODUCT_RAW_F),
            .OUT_I (attn_pkg::PRODUCT_I),
            .OUT_F (attn_pkg::PRODUCT_F)
        ) u_prod_conv (
            .in  (raw[p]),
            .out (prod[p])
        );
    end

    // V rides through the tree with its row
    tree_reduce #(
        .N_IN   (attn_pkg::EMBED_DIM),
        .side_t (attn_pkg::vec_t)
    ) u_tree (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (all_valid),
        .in_ready  (tree_ready),
        .leaves    (prod),
        .side_in   (v_r),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .sum       (sum),
        .side_out  (v_out)
    );

    // Divide by sqrt of dimension
    assign scaled = sum >>> attn_pkg::SCALE_SHIFT;

    q_convert #(
        .IN_I  (attn_pkg::DOT_I),
        .IN_F  (attn_pkg::DOT_F),
        .OUT_I (attn_pkg::SCORE_I),
        .OUT_F (attn_pkg::SCORE_F)
    ) u_score_conv (
        .in  (scaled),
        .out (score)
    );

    assign beat.score = score;
    assign beat.v     = v_out;

endmodule

`default_nettype wire

// File: hdl/attention_score_top.sv
// ########################################
// Attention score subsystem top level
// ########################################
`timescale 1ns/1ns
`default_nettype none

module attention_score_top #(
    // Key rows per query
    parameter int SEQ_LEN = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  attn_pkg::vec_t        q_in,
    input  attn_pkg::vec_t        k_in,
    input  attn_pkg::vec_t        v_in,
    input  logic                  q_valid,
    input  logic                  k_valid,
    input  logic                  v_valid,
    output logic                  q_ready,
    output logic                  k_ready,
    output logic                  v_ready,
    output attn_pkg::score_beat_t beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    // Score pipeline, no extra stages here
    dot_product #(
        .SEQ_LEN (SEQ_LEN)
    ) u_dot (
        .clk       (clk),
        .rst       (rst),
        .q_in      (q_in),
        .k_in      (k_in),
        .v_in      (v_in),
        .q_valid   (q_valid),
        .k_valid   (k_valid),
        .v_valid   (v_valid),
        .q_ready   (q_ready),
        .k_ready   (k_ready),
        .v_ready   (v_ready),
        .beat      (beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: tests/tb_attention_score.sv
// ########################################
// Testbench for the attention score subsystem
// Directed streams checked against a reference model
// ########################################
`timescale 1ns/1ns
`default_nettype none

module tb_attention_score;

    localparam int SEQ_LEN = 4;
    // Output can transfer on this edge after the last input transfer
    localparam int LATENCY = attn_pkg::REDUCE_STAGES + 1;
    // Tests take a few hundred cycles, limit is several times that
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk = 1'b0;
    logic rst;
    attn_pkg::vec_t q_in;
    attn_pkg::vec_t k_in;
    attn_pkg::vec_t v_in;
    logic q_valid;
    logic k_valid;
    logic v_valid;
    logic q_ready;
    logic k_ready;
    logic v_ready;
    attn_pkg::score_beat_t beat;
    logic out_valid;
    logic out_ready;

    // Pending stimulus and expected beats, in order
    attn_pkg::vec_t q_src [$];
    attn_pkg::vec_t k_src [$];
    attn_pkg::vec_t v_src [$];
    attn_pkg::score_beat_t exp_q [$];

    int errors = 0;
    int cycles = 0;
    // Stream shaping for the current test
    int gap_pct;
    int low_from;
    int low_to;
    bit rand_ready;
    bit full_seen;

    attention_score_top #(
        .SEQ_LEN (SEQ_LEN)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .q_in      (q_in),
        .k_in      (k_in),
        .v_in      (v_in),
        .q_valid   (q_valid),
        .k_valid   (k_valid),
        .v_valid   (v_valid),
        .q_ready   (q_ready),
        .k_ready   (k_ready),
        .v_ready   (v_ready),
        .beat      (beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [135:0] expected,
                             input logic [135:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // Floor each product to Q2.10, sum, divide by 4, floor to Q4.4, clamp
    function automatic attn_pkg::score_t ref_score(input attn_pkg::vec_t q,
                                                   input attn_pkg::vec_t k);
        int acc;
        int lim;
        acc = 0;
        lim = 2 ** (attn_pkg::SCORE_I + attn_pkg::SCORE_F - 1);
        for (int i = 0; i < attn_pkg::EMBED_DIM; i++) begin
            acc += (int'(q[i]) * int'(k[i]))
                   >>> (attn_pkg::PRODUCT_RAW_F - attn_pkg::PRODUCT_F);
        end
        acc = acc >>> attn_pkg::SCALE_SHIFT;
        acc = acc >>> (attn_pkg::DOT_F - attn_pkg::SCORE_F);
        if (acc > lim - 1) begin
            acc = lim - 1;
        end else if (acc < -lim) begin
            acc = -lim;
        end
        return attn_pkg::score_t'(acc);
    endfunction

    function automatic attn_pkg::vec_t fill_vec(input attn_pkg::elem_t e);
        attn_pkg::vec_t v;
        for (int i = 0; i < attn_pkg::EMBED_DIM; i++) begin
            v[i] = e;
        end
        return v;
    endfunction

    // Alternating signs with growing magnitude
    function automatic attn_pkg::vec_t mixed_vec();
        attn_pkg::vec_t v;
        for (int i = 0; i < attn_pkg::EMBED_DIM; i++) begin
            v[i] = attn_pkg::elem_t'((i % 2 == 1) ? -(8 * i + 3) : 8 * i + 5);
        end
        return v;
    endfunction

    function automatic attn_pkg::vec_t rand_vec();
        attn_pkg::vec_t v;
        for (int i = 0; i < attn_pkg::EMBED_DIM; i++) begin
            v[i] = attn_pkg::elem_t'($urandom);
        end
        return v;
    endfunction

    function automatic void add_row(input attn_pkg::vec_t q, input attn_pkg::vec_t k,
                                    input attn_pkg::vec_t v);
        attn_pkg::score_beat_t b;
        k_src.push_back(k);
        v_src.push_back(v);
        b.score = ref_score(q, k);
        b.v     = v;
        exp_q.push_back(b);
    endfunction

    // Drives all queued items and checks beats until none is expected
    task automatic run_rows(input string name, input bit check_lat);
        int q_cnt;
        int k_cnt;
        int last_in;
        int t;
        bit q_fire;
        bit k_fire;
        bit v_fire;
        bit stalled;
        attn_pkg::score_beat_t held;
        attn_pkg::score_beat_t e;
        q_cnt   = 0;
        k_cnt   = 0;
        last_in = 0;
        t       = 0;
        stalled = 1'b0;
        while (exp_q.size() > 0) begin
            // Offer the next item on idle streams, gaps by chance
            if (!q_valid && q_src.size() > 0 && ($urandom % 100) >= gap_pct) begin
                q_in    = q_src.pop_front();
                q_valid = 1'b1;
            end
            if (!k_valid && k_src.size() > 0 && ($urandom % 100) >= gap_pct) begin
                k_in    = k_src.pop_front();
                k_valid = 1'b1;
            end
            if (!v_valid && v_src.size() > 0 && ($urandom % 100) >= gap_pct) begin
                v_in    = v_src.pop_front();
                v_valid = 1'b1;
            end
            if (rand_ready) begin
                out_ready = ($urandom % 2) == 1;
            end else begin
                out_ready = !(t >= low_from && t < low_to);
            end
            // Input readies follow out_ready through the tree
            #1;
            // Held beat must not move
            if (stalled) begin
                check_val({name, " stalled valid"}, 1, out_valid);
                check_val({name, " stalled beat"}, held, beat);
            end
            if (out_valid && !out_ready && !k_ready) begin
                full_seen = 1'b1;
            end
            q_fire = q_valid && q_ready;
            k_fire = k_valid && k_ready;
            v_fire = v_valid && v_ready;
            if (q_fire) begin
                if (k_cnt < SEQ_LEN * q_cnt) begin
                    $display("%s: a new Q was accepted before all rows of the previous Q",
                             name);
                    errors++;
                end
                q_cnt++;
            end
            if (q_fire || k_fire || v_fire) begin
                last_in = t + 1;
            end
            if (k_fire) begin
                k_cnt++;
            end
            if (out_valid && out_ready) begin
                e = exp_q.pop_front();
                check_val({name, " score"}, e.score, beat.score);
                check_val({name, " v"}, e.v, beat.v);
                if (check_lat) begin
                    check_val({name, " latency"}, LATENCY, t + 1 - last_in);
                end
            end
            stalled = out_valid && !out_ready;
            held    = beat;
            @(posedge clk);
            #2;
            t++;
            if (q_fire) begin
                q_valid = 1'b0;
            end
            if (k_fire) begin
                k_valid = 1'b0;
            end
            if (v_fire) begin
                v_valid = 1'b0;
            end
        end
        out_ready = 1'b1;
    endtask

    task automatic test_reset();
        check_val("reset out_valid", 0, out_valid);
        check_val("reset q_ready", 1, q_ready);
        check_val("reset k_ready", 1, k_ready);
        check_val("reset v_ready", 1, v_ready);
    endtask

    // One row in flight at a time, so latency is exact
    task automatic test_single();
        attn_pkg::vec_t q;
        q = mixed_vec();
        q_src.push_back(q);
        add_row(q, fill_vec(8'h00), rand_vec());
        run_rows("single zero", 1'b1);
        add_row(q, fill_vec(8'h7f), rand_vec());
        run_rows("single max", 1'b1);
        add_row(q, mixed_vec(), rand_vec());
        run_rows("single mixed", 1'b1);
        add_row(q, fill_vec(8'hff), rand_vec());
        run_rows("single all ones", 1'b1);
    endtask

    // Second Q waits while the first one still has rows
    task automatic test_q_reuse();
        attn_pkg::vec_t qa;
        attn_pkg::vec_t qb;
        qa = rand_vec();
        qb = rand_vec();
        q_src.push_back(qa);
        q_src.push_back(qb);
        for (int r = 0; r < 2 * SEQ_LEN; r++) begin
            add_row((r < SEQ_LEN) ? qa : qb, rand_vec(), rand_vec());
        end
        gap_pct = 50;
        run_rows("q reuse", 1'b0);
        gap_pct = 0;
    endtask

    // Largest same-sign and opposite-sign magnitudes
    task automatic test_extremes();
        attn_pkg::vec_t hi;
        attn_pkg::vec_t lo;
        hi = fill_vec(8'h7f);
        lo = fill_vec(8'h80);
        q_src.push_back(hi);
        q_src.push_back(lo);
        for (int r = 0; r < 2 * SEQ_LEN; r++) begin
            add_row((r < SEQ_LEN) ? hi : lo, (r % 2 == 0) ? hi : lo, rand_vec());
        end
        run_rows("extremes", 1'b0);
    endtask

    task automatic test_backpressure();
        attn_pkg::vec_t qa;
        attn_pkg::vec_t qb;
        qa = rand_vec();
        qb = rand_vec();
        q_src.push_back(qa);
        q_src.push_back(qb);
        for (int r = 0; r < 2 * SEQ_LEN; r++) begin
            add_row((r < SEQ_LEN) ? qa : qb, rand_vec(), rand_vec());
        end
        full_seen = 1'b0;
        low_from  = 2;
        low_to    = 16;
        run_rows("backpressure", 1'b0);
        low_to = 0;
        check_val("backpressure k_ready low when full", 1, full_seen);
    endtask

    task automatic test_random();
        attn_pkg::vec_t q;
        for (int n = 0; n < 3; n++) begin
            q = rand_vec();
            q_src.push_back(q);
            for (int r = 0; r < SEQ_LEN; r++) begin
                add_row(q, rand_vec(), rand_vec());
            end
        end
        gap_pct    = 30;
        rand_ready = 1'b1;
        run_rows("random", 1'b0);
        gap_pct    = 0;
        rand_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h14c1));
        rst        = 1'b1;
        q_in       = '0;
        k_in       = '0;
        v_in       = '0;
        q_valid    = 1'b0;
        k_valid    = 1'b0;
        v_valid    = 1'b0;
        out_ready  = 1'b1;
        gap_pct    = 0;
        low_from   = 0;
        low_to     = 0;
        rand_ready = 1'b0;
        full_seen  = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_single();
        test_q_reuse();
        test_extremes();
        test_backpressure();
        test_random();
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/attn_pkg.sv
hdl/q_convert.sv
hdl/tree_reduce.sv
hdl/dot_product.sv
hdl/attention_score_top.sv
tests/tb_attention_score.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, pass only if the output says so
verilator --binary -Wno-fatal --top-module tb_attention_score -f filelist.f \
    -o tb_attention_score \
    && ./obj_dir/tb_attention_score | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
